// ==== hw/cpuTypesPkg.sv ====
package cpuTypesPkg;

    typedef logic [31:0] word;
    typedef logic [29:0] wordAddress;   // byte address without bits 1:0
    typedef logic [4:0]  regIndex;

    // where a bypass mux takes its operand from
    typedef enum logic [1:0] {
        fwdRegister  = 2'd0,
        fwdMemory    = 2'd1,
        fwdWriteback = 2'd2
    } fwdSel;

    // shared by the decode and execute bypass muxes
    function automatic word selectOperand(
        input fwdSel select,
        input word   regValue,
        input word   memValue,
        input word   wbValue
    );
        case (select)
            fwdMemory:    return memValue;
            fwdWriteback: return wbValue;
            default:      return regValue;
        endcase
    endfunction

endpackage

// ==== hw/isaPkg.sv ====
package isaPkg;

    localparam int opcodeLsb   = 26;
    localparam int rsLsb       = 21;
    localparam int rtLsb       = 16;
    localparam int rdLsb       = 11;
    localparam int shamtLsb    = 6;
    localparam int functLsb    = 0;
    localparam int immWidth    = 16;
    localparam int targetWidth = 26;   // jump target field

    typedef enum logic [5:0] {
        opSpecial = 6'h00,   // register type, see functCode
        opJump    = 6'h02,
        opBeq     = 6'h04,
        opBne     = 6'h05,
        opAddiu   = 6'h09,
        opSlti    = 6'h0a,
        opAndi    = 6'h0c,
        opOri     = 6'h0d,
        opLui     = 6'h0f,
        opLw      = 6'h23,
        opSw      = 6'h2b
    } opcode;

    typedef enum logic [5:0] {
        fnSll  = 6'h00,
        fnSrl  = 6'h02,
        fnAddu = 6'h21,
        fnSubu = 6'h23,
        fnAnd  = 6'h24,
        fnOr   = 6'h25,
        fnXor  = 6'h26,
        fnSlt  = 6'h2a
    } functCode;

    typedef enum logic [3:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluXor,
        aluSlt,
        aluSll,
        aluSrl,
        aluLui
    } aluOp;

    typedef enum logic [1:0] {
        pcSequential,
        pcJump,
        pcBranch
    } nextPcSel;

endpackage

// ==== hw/pipelineControl.sv ====
`timescale 1ns/1ps

module pipelineControl
    import cpuTypesPkg::*;
    import isaPkg::*;
(
    input  logic     clock,
    input  logic     reset,
    input  word      decodeInstruction,
    input  logic     branchEqual,
    input  regIndex  exDest,
    input  regIndex  memDest,
    input  regIndex  wbDest,
    input  logic     exRegWrite,
    input  logic     exMemRead,
    input  logic     memRegWrite,
    input  logic     memLoad,       // load sitting in the memory stage
    input  logic     wbRegWrite,
    input  logic     memoryStall,
    output aluOp     aluOperation,
    output logic     useImmediate,
    output logic     zeroExtend,
    output logic     writeRt,
    output logic     regWrite,
    output logic     memRead,
    output logic     memWrite,
    output fwdSel    decodeFwdA,
    output fwdSel    decodeFwdB,
    output fwdSel    executeFwdA,
    output fwdSel    executeFwdB,
    output nextPcSel pcSelect,
    output logic     fetchStall,
    output logic     bubble
);

    opcode    op;
    functCode funct;
    regIndex  rs;
    regIndex  rt;
    regIndex  exRs;
    regIndex  exRt;
    logic     isBranch;
    logic     usesRs;
    logic     usesRt;
    logic     loadUse;
    logic     branchWait;

    function automatic fwdSel pickSource(
        input regIndex src,
        input logic    memHit,
        input logic    wbHit
    );
        if (src == 5'd0) return fwdRegister;   // r0 is never bypassed
        if (memHit) return fwdMemory;          // youngest result wins
        if (wbHit) return fwdWriteback;
        return fwdRegister;
    endfunction

    assign op    = opcode'(decodeInstruction[opcodeLsb +: 6]);
    assign funct = functCode'(decodeInstruction[functLsb +: 6]);
    assign rs    = decodeInstruction[rsLsb +: 5];
    assign rt    = decodeInstruction[rtLsb +: 5];

    always_comb begin
        aluOperation = aluAdd;
        useImmediate = 1'b0;
        zeroExtend   = 1'b0;
        writeRt      = 1'b0;
        regWrite     = 1'b0;
        memRead      = 1'b0;
        memWrite     = 1'b0;
        isBranch     = 1'b0;
        usesRs       = 1'b1;
        usesRt       = 1'b0;
        pcSelect     = pcSequential;
        case (op)
            opSpecial: begin
                usesRt   = 1'b1;
                regWrite = 1'b1;
                case (funct)
                    fnAddu:  aluOperation = aluAdd;
                    fnSubu:  aluOperation = aluSub;
                    fnAnd:   aluOperation = aluAnd;
                    fnOr:    aluOperation = aluOr;
                    fnXor:   aluOperation = aluXor;
                    fnSlt:   aluOperation = aluSlt;
                    fnSll:   aluOperation = aluSll;
                    fnSrl:   aluOperation = aluSrl;
                    default: regWrite = 1'b0;   // unknown function runs as a no-op
                endcase
            end
            opAddiu, opSlti, opAndi, opOri, opLui, opLw: begin
                useImmediate = 1'b1;
                writeRt      = 1'b1;
                regWrite     = 1'b1;
                memRead      = (op == opLw);
                zeroExtend   = (op == opAndi) || (op == opOri);
                usesRs       = (op != opLui);
                case (op)
                    opSlti:  aluOperation = aluSlt;
                    opAndi:  aluOperation = aluAnd;
                    opOri:   aluOperation = aluOr;
                    opLui:   aluOperation = aluLui;
                    default: aluOperation = aluAdd;
                endcase
            end
            opSw: begin
                useImmediate = 1'b1;
                usesRt       = 1'b1;
                memWrite     = 1'b1;
            end
            opBeq, opBne: begin
                usesRt   = 1'b1;
                isBranch = 1'b1;
                if (branchEqual == (op == opBeq))   // beq on equal, bne otherwise
                    pcSelect = pcBranch;
            end
            opJump: begin
                usesRs   = 1'b0;
                pcSelect = pcJump;
            end
            default: usesRs = 1'b0;   // unknown opcode
        endcase
    end

    // a load in execute cannot feed the next instruction in time
    assign loadUse = exMemRead && exDest != 5'd0
                     && ((usesRs && exDest == rs) || (usesRt && exDest == rt));

    // branches compare in decode, so they wait for execute results and loads
    assign branchWait = isBranch
        && ((exRegWrite && exDest != 5'd0 && (exDest == rs || exDest == rt))
            || (memLoad && memDest != 5'd0 && (memDest == rs || memDest == rt)));

    assign fetchStall = loadUse || branchWait;
    assign bubble     = loadUse || branchWait;

    // writeback reaches decode through the register file bypass
    assign decodeFwdA = pickSource(rs, memRegWrite && !memLoad && memDest == rs, 1'b0);
    assign decodeFwdB = pickSource(rt, memRegWrite && !memLoad && memDest == rt, 1'b0);

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            exRs <= '0;
            exRt <= '0;
        end else if (!memoryStall) begin
            exRs <= bubble ? 5'd0 : rs;
            exRt <= bubble ? 5'd0 : rt;
        end
    end

    assign executeFwdA = pickSource(exRs, memRegWrite && memDest == exRs,
                                    wbRegWrite && wbDest == exRs);
    assign executeFwdB = pickSource(exRt, memRegWrite && memDest == exRt,
                                    wbRegWrite && wbDest == exRt);

endmodule

// ==== hw/fetchUnit.sv ====
`timescale 1ns/1ps

module fetchUnit
    import cpuTypesPkg::*;
    import isaPkg::*;
#(
    parameter word resetVector = '0
) (
    input  logic       clock,
    input  logic       reset,
    input  logic       fetchStall,
    input  logic       memoryStall,
    input  nextPcSel   pcSelect,
    input  fwdSel      decodeFwdA,
    input  fwdSel      decodeFwdB,
    input  word        rfA,
    input  word        rfB,
    input  word        memAluResult,
    input  word        wbData,
    input  word        instData,
    output wordAddress instAddress,
    output word        decodeInstruction,
    output word        decodePcPlus4,
    output word        decodeA,
    output word        decodeB,
    output logic       branchEqual
);

    word  pc;
    word  pcPlus4;
    word  nextPc;
    word  branchOffset;
    word  branchTarget;
    word  jumpTarget;
    logic advance;

    assign advance     = !(fetchStall || memoryStall);
    assign pcPlus4     = pc + 32'd4;
    assign instAddress = pc[31:2];

    assign decodeA     = selectOperand(decodeFwdA, rfA, memAluResult, wbData);
    assign decodeB     = selectOperand(decodeFwdB, rfB, memAluResult, wbData);
    assign branchEqual = (decodeA == decodeB);

    // both targets are taken relative to the delay slot address
    assign branchOffset = {{(30 - immWidth){decodeInstruction[immWidth - 1]}},
                           decodeInstruction[immWidth - 1:0], 2'b00};
    assign branchTarget = decodePcPlus4 + branchOffset;
    assign jumpTarget   = {decodePcPlus4[31:28], decodeInstruction[targetWidth - 1:0], 2'b00};

    always_comb begin
        case (pcSelect)
            pcJump:   nextPc = jumpTarget;
            pcBranch: nextPc = branchTarget;
            default:  nextPc = pcPlus4;
        endcase
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            pc                <= resetVector;
            decodeInstruction <= '0;   // sll r0 acts as a no-op
        end else if (advance) begin
            pc                <= nextPc;
            decodeInstruction <= instData;
        end
    end

    always_ff @(posedge clock) begin
        if (advance)
            decodePcPlus4 <= pcPlus4;
    end

endmodule

// ==== hw/registerFile.sv ====
`timescale 1ns/1ps

module registerFile
    import cpuTypesPkg::*;
(
    input  logic    clock,
    input  logic    reset,
    input  regIndex readA,
    input  regIndex readB,
    input  regIndex writeIndex,
    input  logic    writeEnable,
    input  word     writeData,
    output word     dataA,
    output word     dataB
);

    word regs [0:31];
    logic writeLive;

    assign writeLive = writeEnable && writeIndex != 5'd0;   // r0 is never written

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < 32; i++)
                regs[i] <= '0;
        end else if (writeLive) begin
            regs[writeIndex] <= writeData;
        end
    end

    // same-cycle write shows up on the read ports
    assign dataA = (writeLive && writeIndex == readA) ? writeData : regs[readA];
    assign dataB = (writeLive && writeIndex == readB) ? writeData : regs[readB];

endmodule

// ==== hw/executeUnit.sv ====
`timescale 1ns/1ps

module executeUnit
    import cpuTypesPkg::*;
    import isaPkg::*;
(
    input  logic    clock,
    input  logic    reset,
    input  logic    memoryStall,
    input  logic    bubble,
    input  aluOp    aluOperation,
    input  logic    useImmediate,
    input  logic    zeroExtend,
    input  logic    writeRt,
    input  logic    regWrite,
    input  logic    decodeMemRead,
    input  logic    decodeMemWrite,
    input  word     decodeA,
    input  word     decodeB,
    input  word     decodeInstruction,
    input  fwdSel   executeFwdA,
    input  fwdSel   executeFwdB,
    input  word     wbData,
    output regIndex exDest,
    output logic    exRegWrite,
    output logic    exMemRead,
    output word     memAluResult,   // also the memory-stage bypass value
    output word     memStoreData,
    output regIndex memDest,
    output logic    memRegWrite,
    output logic    memRead,
    output logic    memWrite
);

    aluOp       exAluOp;
    logic       exUseImm;
    logic       exZeroExt;
    logic       exWriteRt;
    logic       exMemWrite;
    word        exA;
    word        exB;
    word        exInstruction;
    word        operandA;
    word        operandB;
    word        immValue;
    word        aluB;
    word        aluResult;
    logic [4:0] shamt;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            exAluOp    <= aluAdd;
            exUseImm   <= 1'b0;
            exZeroExt  <= 1'b0;
            exWriteRt  <= 1'b0;
            exRegWrite <= 1'b0;
            exMemRead  <= 1'b0;
            exMemWrite <= 1'b0;
        end else if (!memoryStall) begin
            exAluOp    <= aluOperation;
            exUseImm   <= useImmediate;
            exZeroExt  <= zeroExtend;
            exWriteRt  <= writeRt;
            exRegWrite <= regWrite && !bubble;   // a bubble changes no state
            exMemRead  <= decodeMemRead && !bubble;
            exMemWrite <= decodeMemWrite && !bubble;
        end
    end

    always_ff @(posedge clock) begin
        if (!memoryStall) begin
            exA           <= decodeA;
            exB           <= decodeB;
            exInstruction <= decodeInstruction;
        end
    end

    assign operandA = selectOperand(executeFwdA, exA, memAluResult, wbData);
    assign operandB = selectOperand(executeFwdB, exB, memAluResult, wbData);

    assign immValue = exZeroExt
        ? {{(32 - immWidth){1'b0}}, exInstruction[immWidth - 1:0]}
        : {{(32 - immWidth){exInstruction[immWidth - 1]}}, exInstruction[immWidth - 1:0]};
    assign aluB     = exUseImm ? immValue : operandB;
    assign shamt    = exInstruction[shamtLsb +: 5];
    assign exDest   = exWriteRt ? exInstruction[rtLsb +: 5] : exInstruction[rdLsb +: 5];

    always_comb begin
        case (exAluOp)
            aluSub:  aluResult = operandA - aluB;
            aluAnd:  aluResult = operandA & aluB;
            aluOr:   aluResult = operandA | aluB;
            aluXor:  aluResult = operandA ^ aluB;
            aluSlt:  aluResult = {31'd0, $signed(operandA) < $signed(aluB)};
            aluSll:  aluResult = aluB << shamt;   // shifts work on rt
            aluSrl:  aluResult = aluB >> shamt;
            aluLui:  aluResult = {aluB[15:0], 16'd0};
            default: aluResult = operandA + aluB;
        endcase
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            memRegWrite <= 1'b0;
            memRead     <= 1'b0;
            memWrite    <= 1'b0;
        end else if (!memoryStall) begin
            memRegWrite <= exRegWrite;
            memRead     <= exMemRead;
            memWrite    <= exMemWrite;
        end
    end

    always_ff @(posedge clock) begin
        if (!memoryStall) begin
            memAluResult <= aluResult;
            memStoreData <= operandB;   // bypassed rt for stores
            memDest      <= exDest;
        end
    end

endmodule

// ==== hw/memoryAccess.sv ====
`timescale 1ns/1ps

module memoryAccess
    import cpuTypesPkg::*;
(
    input  logic       clock,
    input  logic       reset,
    input  word        memAluResult,
    input  word        memStoreData,
    input  regIndex    memDest,
    input  logic       memRegWrite,
    input  logic       memRead,
    input  logic       memWrite,
    output wordAddress dataAddress,
    output word        dataWriteData,
    output logic       dataRead,
    output logic       dataWrite,
    input  word        dataReadData,
    input  logic       dataReady,
    output logic       memoryStall,
    output regIndex    wbDest,
    output logic       wbRegWrite,      // bypass qualifier
    output logic       wbWriteEnable,   // register file write, once per instruction
    output word        wbData
);

    logic frozenLast;   // writeback already wrote during the previous frozen cycle

    // the execute-to-memory register holds the request steady until ready
    assign dataAddress   = memAluResult[31:2];
    assign dataWriteData = memStoreData;
    assign dataRead      = memRead;
    assign dataWrite     = memWrite;
    assign memoryStall   = (memRead || memWrite) && !dataReady;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            wbRegWrite <= 1'b0;
            frozenLast <= 1'b0;
        end else begin
            frozenLast <= memoryStall;
            if (!memoryStall)
                wbRegWrite <= memRegWrite;
        end
    end

    always_ff @(posedge clock) begin
        if (!memoryStall) begin
            wbDest <= memDest;
            wbData <= memRead ? dataReadData : memAluResult;   // load data on the ready cycle
        end
    end

    assign wbWriteEnable = wbRegWrite && !frozenLast;

endmodule

// ==== hw/mipsCore.sv ====
`timescale 1ns/1ps

module mipsCore
    import cpuTypesPkg::*;
    import isaPkg::*;
#(
    parameter word resetVector = '0
) (
    input  logic       clock,
    input  logic       reset,
    output wordAddress instAddress,
    input  word        instData,
    output wordAddress dataAddress,
    output word        dataWriteData,
    output logic       dataRead,
    output logic       dataWrite,
    input  word        dataReadData,
    input  logic       dataReady
);

    word      decodeInstruction;
    word      decodeA;
    word      decodeB;
    word      rfA;
    word      rfB;
    word      memAluResult;
    word      memStoreData;
    word      wbData;
    logic     branchEqual;
    logic     fetchStall;
    logic     bubble;
    logic     memoryStall;
    aluOp     aluOperation;
    logic     useImmediate;
    logic     zeroExtend;
    logic     writeRt;
    logic     regWrite;
    logic     decodeMemRead;    // decoded, still in decode
    logic     decodeMemWrite;
    fwdSel    decodeFwdA;
    fwdSel    decodeFwdB;
    fwdSel    executeFwdA;
    fwdSel    executeFwdB;
    nextPcSel pcSelect;
    regIndex  exDest;
    regIndex  memDest;
    regIndex  wbDest;
    logic     exRegWrite;
    logic     exMemRead;
    logic     memRegWrite;
    logic     memRead;
    logic     memWrite;
    logic     wbRegWrite;
    logic     wbWriteEnable;

    pipelineControl control (
        .clock,
        .reset,
        .decodeInstruction,
        .branchEqual,
        .exDest,
        .memDest,
        .wbDest,
        .exRegWrite,
        .exMemRead,
        .memRegWrite,
        .memLoad      (memRead),
        .wbRegWrite,
        .memoryStall,
        .aluOperation,
        .useImmediate,
        .zeroExtend,
        .writeRt,
        .regWrite,
        .memRead      (decodeMemRead),
        .memWrite     (decodeMemWrite),
        .decodeFwdA,
        .decodeFwdB,
        .executeFwdA,
        .executeFwdB,
        .pcSelect,
        .fetchStall,
        .bubble
    );

    fetchUnit #(
        .resetVector (resetVector)
    ) fetch (
        .clock,
        .reset,
        .fetchStall,
        .memoryStall,
        .pcSelect,
        .decodeFwdA,
        .decodeFwdB,
        .rfA,
        .rfB,
        .memAluResult,
        .wbData,
        .instData,
        .instAddress,
        .decodeInstruction,
        .decodePcPlus4 (),
        .decodeA,
        .decodeB,
        .branchEqual
    );

    registerFile regFile (
        .clock,
        .reset,
        .readA       (decodeInstruction[rsLsb +: 5]),
        .readB       (decodeInstruction[rtLsb +: 5]),
        .writeIndex  (wbDest),
        .writeEnable (wbWriteEnable),
        .writeData   (wbData),
        .dataA       (rfA),
        .dataB       (rfB)
    );

    executeUnit execute (
        .clock,
        .reset,
        .memoryStall,
        .bubble,
        .aluOperation,
        .useImmediate,
        .zeroExtend,
        .writeRt,
        .regWrite,
        .decodeMemRead,
        .decodeMemWrite,
        .decodeA,
        .decodeB,
        .decodeInstruction,
        .executeFwdA,
        .executeFwdB,
        .wbData,
        .exDest,
        .exRegWrite,
        .exMemRead,
        .memAluResult,
        .memStoreData,
        .memDest,
        .memRegWrite,
        .memRead,
        .memWrite
    );

    memoryAccess memory (
        .clock,
        .reset,
        .memAluResult,
        .memStoreData,
        .memDest,
        .memRegWrite,
        .memRead,
        .memWrite,
        .dataAddress,
        .dataWriteData,
        .dataRead,
        .dataWrite,
        .dataReadData,
        .dataReady,
        .memoryStall,
        .wbDest,
        .wbRegWrite,
        .wbWriteEnable,
        .wbData
    );

endmodule

// ==== verification/storeChecker.sv ====
`timescale 1ns/1ps

module storeChecker (
    input  logic        clock,
    input  logic        reset,
    input  logic [29:0] dataAddress,
    input  logic [31:0] dataWriteData,
    input  logic        dataRead,
    input  logic        dataWrite,
    input  logic        dataReady,
    input  logic [29:0] expAddress [0:31],
    input  logic [31:0] expData [0:31],
    input  int          expCount,
    output logic        markerSeen,
    output int          testErrors,
    output int          storeCount
);

    localparam logic [29:0] markerAddress = 30'h3fffffff;   // byte address 0xfffffffc

    int          newErrors;
    logic        waiting;         // request open without dataReady last cycle
    logic [29:0] heldAddress;
    logic [31:0] heldWriteData;
    logic        heldRead;
    logic        heldWrite;

    always @(posedge clock or posedge reset) begin
        if (reset) begin
            markerSeen <= 1'b0;
            testErrors <= 0;
            storeCount <= 0;
            waiting    <= 1'b0;
        end else if (!markerSeen) begin
            newErrors = 0;
            // an open request holds still until dataReady
            if (waiting) begin
                if (dataRead != heldRead) begin
                    $display("error at %0t ns: dataRead expected %b, got %b", $time,
                             heldRead, dataRead);
                    newErrors++;
                end
                if (dataWrite != heldWrite) begin
                    $display("error at %0t ns: dataWrite expected %b, got %b", $time,
                             heldWrite, dataWrite);
                    newErrors++;
                end
                if (dataAddress != heldAddress) begin
                    $display("error at %0t ns: dataAddress expected %h, got %h", $time,
                             heldAddress, dataAddress);
                    newErrors++;
                end
                if (heldWrite && dataWriteData != heldWriteData) begin
                    $display("error at %0t ns: dataWriteData expected %h, got %h", $time,
                             heldWriteData, dataWriteData);
                    newErrors++;
                end
            end
            waiting       <= (dataRead || dataWrite) && !dataReady;
            heldAddress   <= dataAddress;
            heldWriteData <= dataWriteData;
            heldRead      <= dataRead;
            heldWrite     <= dataWrite;
            // a write counts only in the cycle that completes it
            if (dataWrite && dataReady) begin
                if (dataAddress == markerAddress) begin
                    markerSeen <= 1'b1;
                    if (storeCount != expCount) begin
                        $display("wrong number of stores before the marker: %0d seen, %0d expected",
                                 storeCount, expCount);
                        newErrors++;
                    end
                end else if (storeCount >= expCount) begin
                    $display("extra store to word address %h with data %h", dataAddress,
                             dataWriteData);
                    newErrors++;
                    storeCount <= storeCount + 1;
                end else begin
                    if (dataAddress != expAddress[storeCount]) begin
                        $display("error at %0t ns: dataAddress expected %h, got %h", $time,
                                 expAddress[storeCount], dataAddress);
                        newErrors++;
                    end
                    if (dataWriteData != expData[storeCount]) begin
                        $display("error at %0t ns: dataWriteData expected %h, got %h", $time,
                                 expData[storeCount], dataWriteData);
                        newErrors++;
                    end
                    storeCount <= storeCount + 1;
                end
            end
            testErrors <= testErrors + newErrors;
        end
    end

endmodule

// ==== verification/coreTb.sv ====
`timescale 1ns/1ps

module coreTb;

    localparam string casePath = "verification/programCases.txt";
    localparam int    maxDelay = 3;   // worst dataReady delay in cycles

    logic        clock;
    logic        reset;
    logic [29:0] instAddress;
    logic [31:0] instData;
    logic [29:0] dataAddress;
    logic [31:0] dataWriteData;
    logic        dataRead;
    logic        dataWrite;
    logic [31:0] dataReadData;
    logic        dataReady;

    logic [31:0] instMem [0:255];
    logic [31:0] dataMem [0:1023];
    logic [29:0] expAddress [0:31];
    logic [31:0] expData [0:31];
    int          expCount;
    logic        markerSeen;
    int          testErrors;
    int          storeCount;

    int    cycleCount = 0;
    int    cycleLimit = 0;
    int    delayLeft;
    int    loadIndex;
    int    testsRun;
    int    testsFailed;
    int    totalErrors;
    int    badLines;
    int    instTotal;
    int    seedValue;
    int    fd;
    string line;
    string testName;

    assign instData     = instMem[instAddress[7:0]];   // combinational fetch
    assign dataReadData = dataMem[dataAddress[9:0]];

    mipsCore #(
        .resetVector (32'h0)
    ) u_dut (
        .clock,
        .reset,
        .instAddress,
        .instData,
        .dataAddress,
        .dataWriteData,
        .dataRead,
        .dataWrite,
        .dataReadData,
        .dataReady
    );

    storeChecker stores (
        .clock,
        .reset,
        .dataAddress,
        .dataWriteData,
        .dataRead,
        .dataWrite,
        .dataReady,
        .expAddress,
        .expData,
        .expCount,
        .markerSeen,
        .testErrors,
        .storeCount
    );

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    always @(posedge clock) begin
        if (dataWrite && dataReady)
            dataMem[dataAddress[9:0]] <= dataWriteData;
    end

    // each request waits a fresh random number of cycles
    initial begin
        dataReady = 1'b0;
        delayLeft = -1;
        seedValue = $urandom(32'he83f_bec9);
        forever begin
            @(posedge clock);
            #1;
            if (reset || !(dataRead || dataWrite)) begin
                dataReady = 1'b0;
                delayLeft = -1;
            end else begin
                if (delayLeft < 0)
                    delayLeft = $urandom_range(maxDelay, 0);
                if (delayLeft == 0) begin
                    dataReady = 1'b1;
                    delayLeft = -1;
                end else begin
                    dataReady = 1'b0;
                    delayLeft--;
                end
            end
        end
    end

    always @(posedge clock) begin
        cycleCount <= cycleCount + 1;
        if (cycleLimit > 0 && cycleCount >= cycleLimit) begin
            $display("timeout: no marker store after %0d cycles", cycleCount);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    task automatic countInstructions(output int total);
        int    countFd;
        string text;
        total   = 0;
        countFd = $fopen(casePath, "r");
        if (countFd == 0)
            return;
        while ($fgets(text, countFd) != 0) begin
            if (text.len() > 0 && text.getc(0) == "I")
                total++;
        end
        $fclose(countFd);
    endtask

    // hold the core in reset while the next program is loaded
    task automatic startTest();
        @(posedge clock);
        #1;
        reset = 1'b1;
        for (int i = 0; i < 256; i++)
            instMem[i] = 32'h0;
        for (int i = 0; i < 1024; i++)
            dataMem[i] = 32'h5eed_0000 ^ (i * 32'h0001_0003);
        loadIndex = 0;
        expCount  = 0;
    endtask

    task automatic runTest();
        repeat (16) @(posedge clock);
        #1;
        reset = 1'b0;
        wait (markerSeen);
        testsRun++;
        totalErrors += testErrors;
        if (testErrors != 0) begin
            testsFailed++;
            $display("test %s failed with %0d errors", testName, testErrors);
        end else begin
            $display("test %s passed, %0d stores checked", testName, storeCount);
        end
    endtask

    task automatic handleLine(input string text);
        logic [31:0] first;
        logic [31:0] second;
        int          fields;
        int          wanted;
        if (text.len() < 1)
            return;
        fields = 0;
        wanted = 0;
        case (text.getc(0))
            "T": begin
                fields = $sscanf(text, "T %s", testName);
                wanted = 1;
                startTest();
            end
            "I": begin
                fields = $sscanf(text, "I %h", first);
                wanted = 1;
                instMem[loadIndex] = first;
                loadIndex++;
            end
            "D": begin
                fields = $sscanf(text, "D %h %h", first, second);
                wanted = 2;
                dataMem[first[9:0]] = second;
            end
            "S": begin
                fields = $sscanf(text, "S %h %h", first, second);
                wanted = 2;
                expAddress[expCount] = first[29:0];
                expData[expCount]    = second;
                expCount++;
            end
            "E": runTest();
            default: ;   // comment or blank line
        endcase
        if (fields != wanted) begin
            $display("malformed line in case file: %s", text);
            badLines++;
        end
    endtask

    initial begin
        reset       = 1'b1;
        expCount    = 0;
        testsRun    = 0;
        testsFailed = 0;
        totalErrors = 0;
        badLines    = 0;
        for (int i = 0; i < 32; i++) begin
            expAddress[i] = '0;
            expData[i]    = '0;
        end
        countInstructions(instTotal);
        cycleLimit = 8 * (instTotal + 4) * (maxDelay + 1);
        fd = $fopen(casePath, "r");
        if (fd == 0) begin
            $display("cannot open case file %s", casePath);
            $display("RESULT: FAIL");
            $finish;
        end else begin
            while ($fgets(line, fd) != 0)
                handleLine(line);
            $fclose(fd);
            $display("%0d tests run, %0d failed, %0d errors", testsRun, testsFailed,
                     totalErrors);
            if (testsRun > 0 && testsFailed == 0 && badLines == 0)
                $display("RESULT: PASS");
            else
                $display("RESULT: FAIL");
            $finish;
        end
    end

endmodule

// ==== verification/programCases.txt ====
# T name | I instruction word | D word address, data | S expected store word address, data
# E runs the test; every program ends with a store to the marker at byte address 0xfffffffc
T registerOps
I 3c011234
I 34215678
I 2402fff0
I 00221821
I 00222023
I 00222824
I 00223025
I 00223826
I 0041402a
I 00014900
I 00015202
I ac030100
I ac040104
I ac050108
I ac06010c
I ac070110
I ac080114
I ac090118
I ac0a011c
I ac00fffc
S 040 12345668
S 041 12345688
S 042 12345670
S 043 fffffff8
S 044 edcba988
S 045 00000001
S 046 23456780
S 047 00123456
E
T immediateOps
I 24018000
I 3022f0f0
I 34038001
I 2824ffff
I 3c05abcd
I 24000005
I 00003021
I ac010120
I ac020124
I ac030128
I ac04012c
I ac050130
I ac000134
I ac060138
I ac00fffc
S 048 ffff8000
S 049 00008000
S 04a 00008001
S 04b 00000001
S 04c abcd0000
S 04d 00000000
S 04e 00000000
E
T loadUse
D 050 cafef00d
D 051 00000011
I 8c010140
I 24220001
I 8c030144
I ac030148
I ac02014c
I 8c040148
I 00842821
I ac050150
I ac00fffc
S 052 00000011
S 053 cafef00e
S 054 00000022
E
T branchJump
I 24010007
I 24020007
I 10220003
I 24030033
I ac010200
I ac010204
I ac030160
I 14220005
I 24040044
I ac040164
I 24050009
I 14a10003
I 24060066
I ac000208
I ac00020c
I ac060168
I 10a10005
I 00000000
I 08000015
I 24070077
I ac000210
I ac07016c
I ac00fffc
S 058 00000033
S 059 00000044
S 05a 00000066
S 05b 00000077
E

// ==== all.f ====
hw/cpuTypesPkg.sv
hw/isaPkg.sv
hw/pipelineControl.sv
hw/fetchUnit.sv
hw/registerFile.sv
hw/executeUnit.sv
hw/memoryAccess.sv
hw/mipsCore.sv
verification/storeChecker.sv
verification/coreTb.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --top-module coreTb -f all.f -o coreSim &&
./obj_dir/coreSim | tee /dev/stderr | grep -q "RESULT: PASS" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
